// File: stripe_macros.svh
`ifndef STRIPE_MACROS_SVH
`define STRIPE_MACROS_SVH

// Lane count, must be a power of two
`define STRIPE_NUM_S 2

`define STRIPE_ADDR_W 9
`define STRIPE_DATA_W 16
`define STRIPE_ID_W 4

// Words held by each lane memory
`define STRIPE_LANE_WORDS 64

`endif

// File: stripe_pkg.sv
`default_nettype none

`include "stripe_macros.svh"

package stripe_pkg;

  localparam int LANE_BITS = $clog2(`STRIPE_NUM_S);
  localparam int BYTE_BITS = $clog2(`STRIPE_DATA_W / 8);
  localparam int WORD_W = `STRIPE_ADDR_W - BYTE_BITS;
  localparam int LANE_ADDR_W = WORD_W - LANE_BITS;

  // Lane number sits in the low bits of the word index
  typedef struct packed {
    logic [LANE_ADDR_W-1:0] addr;
    logic [LANE_BITS-1:0]   lane;
  } lane_word_t;

  typedef union packed {
    logic [WORD_W-1:0] word;
    lane_word_t        split;
  } stripe_addr_u;

  // AXI len of the share of a burst seen by one lane
  function automatic logic [7:0] lane_len(input logic [7:0] len);
    logic [8:0] beats;
    beats = {1'b0, len} + 9'd1;
    return 8'((beats >> LANE_BITS) - 9'd1);
  endfunction

endpackage

`default_nettype wire

// File: axi_types_pkg.sv
`default_nettype none

`include "stripe_macros.svh"

package axi_types_pkg;

  // Larger code is the worse response
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic [`STRIPE_ID_W-1:0]   id;
    logic [`STRIPE_ADDR_W-1:0] addr;
    logic [7:0]                len;
    logic [2:0]                size;
    logic [1:0]                burst;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  // Lane side carries the lane-local word address
  typedef struct packed {
    logic [`STRIPE_ID_W-1:0]           id;
    logic [stripe_pkg::LANE_ADDR_W-1:0] addr;
    logic [7:0]                        len;
    logic [2:0]                        size;
    logic [1:0]                        burst;
  } axi_law_t;

  typedef axi_law_t axi_lar_t;

  typedef struct packed {
    logic [`STRIPE_DATA_W-1:0]   data;
    logic [`STRIPE_DATA_W/8-1:0] strb;
    logic                        last;
  } axi_w_t;

  typedef struct packed {
    logic [`STRIPE_ID_W-1:0] id;
    logic [1:0]              resp;
  } axi_b_t;

  typedef struct packed {
    logic [`STRIPE_ID_W-1:0]   id;
    logic [`STRIPE_DATA_W-1:0] data;
    logic [1:0]                resp;
    logic                      last;
  } axi_r_t;

endpackage

`default_nettype wire

// File: stripe_wr.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module stripe_wr (
  input  logic                                        clk,
  input  logic                                        i_rst,

  input  axi_types_pkg::axi_aw_t                      i_aw,
  input  logic                                        i_aw_valid,
  output logic                                        o_aw_ready,
  input  axi_types_pkg::axi_w_t                       i_w,
  input  logic                                        i_w_valid,
  output logic                                        o_w_ready,
  output axi_types_pkg::axi_b_t                       o_b,
  output logic                                        o_b_valid,
  input  logic                                        i_b_ready,

  output axi_types_pkg::axi_law_t [`STRIPE_NUM_S-1:0] o_law,
  output logic [`STRIPE_NUM_S-1:0]                    o_law_valid,
  input  logic [`STRIPE_NUM_S-1:0]                    i_law_ready,
  output axi_types_pkg::axi_w_t [`STRIPE_NUM_S-1:0]   o_lw,
  output logic [`STRIPE_NUM_S-1:0]                    o_lw_valid,
  input  logic [`STRIPE_NUM_S-1:0]                    i_lw_ready,
  input  axi_types_pkg::axi_b_t [`STRIPE_NUM_S-1:0]   i_lb,
  input  logic [`STRIPE_NUM_S-1:0]                    i_lb_valid,
  output logic [`STRIPE_NUM_S-1:0]                    o_lb_ready
);
  import axi_types_pkg::*;
  import stripe_pkg::*;

  localparam int NUM_S = `STRIPE_NUM_S;

  stripe_addr_u         start;
  axi_law_t             law_q;
  axi_w_t               lw;
  logic                 wr_busy;
  logic                 w_open;
  logic [LANE_BITS-1:0] w_lane;
  logic [7:0]           w_round;
  logic [NUM_S-1:0]     b_done;
  logic [NUM_S-1:0]     lb_hs;
  logic [1:0]           resp_next;
  logic                 aw_hs;
  logic                 w_hs;
  logic                 b_hs;

  assign start.word = i_aw.addr[`STRIPE_ADDR_W-1:BYTE_BITS];
  assign aw_hs = i_aw_valid && o_aw_ready;
  assign w_hs = i_w_valid && o_w_ready;
  assign b_hs = o_b_valid && i_b_ready;
  assign lb_hs = i_lb_valid & o_lb_ready;

  // Every lane sees the same AW, and the same W payload
  assign o_law = {NUM_S{law_q}};
  assign lw = '{data: i_w.data, strb: i_w.strb, last: w_round == law_q.len};
  assign o_lw = {NUM_S{lw}};

  // Port W follows the lane picked by the rolling counter
  assign o_w_ready = w_open && i_lw_ready[w_lane];
  assign o_lb_ready = ~b_done;

  always_comb begin
    o_lw_valid = '0;
    o_lw_valid[w_lane] = w_open && i_w_valid;
  end

  // Worst response seen so far, including this cycle's lane responses
  always_comb begin
    resp_next = o_b.resp;
    for (int j = 0; j < NUM_S; j++) begin
      if (lb_hs[j] && i_lb[j].resp > resp_next) begin
        resp_next = i_lb[j].resp;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_aw_ready  <= 1'b0;
      o_law_valid <= '0;
      o_b_valid   <= 1'b0;
      wr_busy     <= 1'b0;
      w_open      <= 1'b0;
      b_done      <= '0;
    end else begin
      o_law_valid <= o_law_valid & ~i_law_ready;
      b_done <= b_done | lb_hs;
      o_b.resp <= resp_next;

      if (aw_hs) begin
        o_aw_ready  <= 1'b0;
        o_law_valid <= '1;
        wr_busy     <= 1'b1;
        w_open      <= 1'b1;
        w_lane      <= '0;
        w_round     <= '0;
        law_q <= '{id: i_aw.id, addr: start.split.addr, len: lane_len(i_aw.len),
                   size: i_aw.size, burst: i_aw.burst};
        o_b.id   <= i_aw.id;
        o_b.resp <= RESP_OKAY;
      end else if (b_hs || !wr_busy) begin
        o_aw_ready <= 1'b1;
      end

      if (w_hs) begin
        w_lane <= w_lane + LANE_BITS'(1);
        // One full round of lanes done
        if (&w_lane) begin
          w_round <= w_round + 8'd1;
          if (lw.last) begin
            w_open <= 1'b0;
          end
        end
      end

      if (&(b_done | lb_hs)) begin
        o_b_valid <= 1'b1;
      end
      if (b_hs) begin
        o_b_valid <= 1'b0;
        b_done    <= '0;
        wr_busy   <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: stripe_rd.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module stripe_rd (
  input  logic                                        clk,
  input  logic                                        i_rst,

  input  axi_types_pkg::axi_ar_t                      i_ar,
  input  logic                                        i_ar_valid,
  output logic                                        o_ar_ready,
  output axi_types_pkg::axi_r_t                       o_r,
  output logic                                        o_r_valid,
  input  logic                                        i_r_ready,

  output axi_types_pkg::axi_lar_t [`STRIPE_NUM_S-1:0] o_lar,
  output logic [`STRIPE_NUM_S-1:0]                    o_lar_valid,
  input  logic [`STRIPE_NUM_S-1:0]                    i_lar_ready,
  input  axi_types_pkg::axi_r_t [`STRIPE_NUM_S-1:0]   i_lr,
  input  logic [`STRIPE_NUM_S-1:0]                    i_lr_valid,
  output logic [`STRIPE_NUM_S-1:0]                    o_lr_ready
);
  import axi_types_pkg::*;
  import stripe_pkg::*;

  localparam int NUM_S = `STRIPE_NUM_S;

  stripe_addr_u         start;
  axi_lar_t             lar_q;
  logic                 r_open;
  logic [LANE_BITS-1:0] r_lane;
  logic [7:0]           r_remain;
  logic                 ar_hs;
  logic                 r_hs;

  assign start.word = i_ar.addr[`STRIPE_ADDR_W-1:BYTE_BITS];
  assign ar_hs = i_ar_valid && o_ar_ready;
  assign r_hs = o_r_valid && i_r_ready;
  assign o_lar = {NUM_S{lar_q}};

  // R comes straight from the selected lane, other lanes hold their data
  always_comb begin
    o_r = i_lr[r_lane];
    o_r.last = r_remain == 8'd0;
    o_r_valid = r_open && i_lr_valid[r_lane];
    o_lr_ready = '0;
    o_lr_ready[r_lane] = r_open && i_r_ready;
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_ar_ready  <= 1'b0;
      o_lar_valid <= '0;
      r_open      <= 1'b0;
    end else begin
      o_lar_valid <= o_lar_valid & ~i_lar_ready;

      if (ar_hs) begin
        o_ar_ready  <= 1'b0;
        o_lar_valid <= '1;
        r_open      <= 1'b1;
        r_lane      <= '0;
        r_remain    <= i_ar.len;
        lar_q <= '{id: i_ar.id, addr: start.split.addr, len: lane_len(i_ar.len),
                   size: i_ar.size, burst: i_ar.burst};
      end else if (!r_open) begin
        o_ar_ready <= 1'b1;
      end

      if (r_hs) begin
        r_lane   <= r_lane + LANE_BITS'(1);
        r_remain <= r_remain - 8'd1;
        // Final beat of the whole burst frees the AR channel
        if (o_r.last) begin
          r_open     <= 1'b0;
          o_ar_ready <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: axi_stripe.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module axi_stripe (
  input  logic                                        clk,
  input  logic                                        i_rst,

  input  axi_types_pkg::axi_aw_t                      i_aw,
  input  logic                                        i_aw_valid,
  output logic                                        o_aw_ready,
  input  axi_types_pkg::axi_w_t                       i_w,
  input  logic                                        i_w_valid,
  output logic                                        o_w_ready,
  output axi_types_pkg::axi_b_t                       o_b,
  output logic                                        o_b_valid,
  input  logic                                        i_b_ready,
  input  axi_types_pkg::axi_ar_t                      i_ar,
  input  logic                                        i_ar_valid,
  output logic                                        o_ar_ready,
  output axi_types_pkg::axi_r_t                       o_r,
  output logic                                        o_r_valid,
  input  logic                                        i_r_ready,

  output axi_types_pkg::axi_law_t [`STRIPE_NUM_S-1:0] o_law,
  output logic [`STRIPE_NUM_S-1:0]                    o_law_valid,
  input  logic [`STRIPE_NUM_S-1:0]                    i_law_ready,
  output axi_types_pkg::axi_w_t [`STRIPE_NUM_S-1:0]   o_lw,
  output logic [`STRIPE_NUM_S-1:0]                    o_lw_valid,
  input  logic [`STRIPE_NUM_S-1:0]                    i_lw_ready,
  input  axi_types_pkg::axi_b_t [`STRIPE_NUM_S-1:0]   i_lb,
  input  logic [`STRIPE_NUM_S-1:0]                    i_lb_valid,
  output logic [`STRIPE_NUM_S-1:0]                    o_lb_ready,
  output axi_types_pkg::axi_lar_t [`STRIPE_NUM_S-1:0] o_lar,
  output logic [`STRIPE_NUM_S-1:0]                    o_lar_valid,
  input  logic [`STRIPE_NUM_S-1:0]                    i_lar_ready,
  input  axi_types_pkg::axi_r_t [`STRIPE_NUM_S-1:0]   i_lr,
  input  logic [`STRIPE_NUM_S-1:0]                    i_lr_valid,
  output logic [`STRIPE_NUM_S-1:0]                    o_lr_ready
);

  // Write and read halves share nothing but the clock and reset
  stripe_wr i_stripe_wr (.*);

  stripe_rd i_stripe_rd (.*);

endmodule

`default_nettype wire

// File: axi_word_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module axi_word_mem (
  input  logic                     clk,
  input  logic                     i_rst,

  input  axi_types_pkg::axi_law_t  i_aw,
  input  logic                     i_aw_valid,
  output logic                     o_aw_ready,
  input  axi_types_pkg::axi_w_t    i_w,
  input  logic                     i_w_valid,
  output logic                     o_w_ready,
  output axi_types_pkg::axi_b_t    o_b,
  output logic                     o_b_valid,
  input  logic                     i_b_ready,
  input  axi_types_pkg::axi_lar_t  i_ar,
  input  logic                     i_ar_valid,
  output logic                     o_ar_ready,
  output axi_types_pkg::axi_r_t    o_r,
  output logic                     o_r_valid,
  input  logic                     i_r_ready
);
  import axi_types_pkg::*;
  import stripe_pkg::*;

  localparam int DEPTH = `STRIPE_LANE_WORDS;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int STRB_W = `STRIPE_DATA_W / 8;
  localparam logic [LANE_ADDR_W:0] LIMIT = (LANE_ADDR_W + 1)'(DEPTH);

  logic [`STRIPE_DATA_W-1:0] mem [DEPTH];
  logic [LANE_ADDR_W:0]      w_addr;
  logic [LANE_ADDR_W:0]      r_addr;
  logic [7:0]                r_left;
  logic [`STRIPE_ID_W-1:0]   r_id;
  logic                      w_err;
  logic                      w_oob;
  logic                      aw_hs;
  logic                      w_hs;
  logic                      b_hs;
  logic                      ar_hs;
  logic                      r_hs;

  // One read beat, zero data and SLVERR past the end of the array
  function automatic axi_r_t rd_beat(input logic [LANE_ADDR_W:0] addr,
                                     input logic [`STRIPE_ID_W-1:0] id, input logic last);
    axi_r_t beat;
    beat.id = id;
    beat.last = last;
    if (addr < LIMIT) begin
      beat.data = mem[addr[IDX_W-1:0]];
      beat.resp = RESP_OKAY;
    end else begin
      beat.data = '0;
      beat.resp = RESP_SLVERR;
    end
    return beat;
  endfunction

  assign aw_hs = i_aw_valid && o_aw_ready;
  assign w_hs = i_w_valid && o_w_ready;
  assign b_hs = o_b_valid && i_b_ready;
  assign ar_hs = i_ar_valid && o_ar_ready;
  assign r_hs = o_r_valid && i_r_ready;
  assign w_oob = w_addr >= LIMIT;

  // One burst per direction, taken once the previous one is fully returned
  assign o_aw_ready = !o_w_ready && !o_b_valid;
  assign o_ar_ready = !o_r_valid && r_left == 8'd0;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_w_ready <= 1'b0;
      o_b_valid <= 1'b0;
    end else begin
      if (aw_hs) begin
        o_w_ready <= 1'b1;
        w_addr    <= {1'b0, i_aw.addr};
        w_err     <= 1'b0;
        o_b.id    <= i_aw.id;
      end
      if (w_hs) begin
        w_addr <= w_addr + (LANE_ADDR_W + 1)'(1);
        w_err  <= w_err || w_oob;
        if (i_w.last) begin
          o_w_ready <= 1'b0;
          o_b_valid <= 1'b1;
          o_b.resp  <= (w_err || w_oob) ? RESP_SLVERR : RESP_OKAY;
        end
      end
      if (b_hs) begin
        o_b_valid <= 1'b0;
      end
    end
  end

  // Out-of-range beats are dropped
  always_ff @(posedge clk) begin
    if (w_hs && !w_oob) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_w.strb[b]) begin
          mem[w_addr[IDX_W-1:0]][8*b +: 8] <= i_w.data[8*b +: 8];
        end
      end
    end
  end

  // First beat is loaded straight from AR, later ones as each is taken
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_r_valid <= 1'b0;
      r_left    <= '0;
    end else if (ar_hs) begin
      o_r_valid <= 1'b1;
      o_r       <= rd_beat({1'b0, i_ar.addr}, i_ar.id, i_ar.len == 8'd0);
      r_addr    <= {1'b0, i_ar.addr} + (LANE_ADDR_W + 1)'(1);
      r_left    <= i_ar.len;
      r_id      <= i_ar.id;
    end else if (r_hs) begin
      if (r_left != 8'd0) begin
        o_r    <= rd_beat(r_addr, r_id, r_left == 8'd1);
        r_addr <= r_addr + (LANE_ADDR_W + 1)'(1);
        r_left <= r_left - 8'd1;
      end else begin
        o_r_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: stripe_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module stripe_mem_top (
  input  logic                   clk,
  input  logic                   i_rst,

  input  axi_types_pkg::axi_aw_t i_aw,
  input  logic                   i_aw_valid,
  output logic                   o_aw_ready,
  input  axi_types_pkg::axi_w_t  i_w,
  input  logic                   i_w_valid,
  output logic                   o_w_ready,
  output axi_types_pkg::axi_b_t  o_b,
  output logic                   o_b_valid,
  input  logic                   i_b_ready,
  input  axi_types_pkg::axi_ar_t i_ar,
  input  logic                   i_ar_valid,
  output logic                   o_ar_ready,
  output axi_types_pkg::axi_r_t  o_r,
  output logic                   o_r_valid,
  input  logic                   i_r_ready
);
  import axi_types_pkg::*;

  localparam int NUM_S = `STRIPE_NUM_S;

  axi_law_t [NUM_S-1:0] law;
  logic [NUM_S-1:0]     law_valid;
  logic [NUM_S-1:0]     law_ready;
  axi_w_t [NUM_S-1:0]   lw;
  logic [NUM_S-1:0]     lw_valid;
  logic [NUM_S-1:0]     lw_ready;
  axi_b_t [NUM_S-1:0]   lb;
  logic [NUM_S-1:0]     lb_valid;
  logic [NUM_S-1:0]     lb_ready;
  axi_lar_t [NUM_S-1:0] lar;
  logic [NUM_S-1:0]     lar_valid;
  logic [NUM_S-1:0]     lar_ready;
  axi_r_t [NUM_S-1:0]   lr;
  logic [NUM_S-1:0]     lr_valid;
  logic [NUM_S-1:0]     lr_ready;

  axi_stripe i_axi_stripe (
    .clk, .i_rst,
    .i_aw, .i_aw_valid, .o_aw_ready,
    .i_w, .i_w_valid, .o_w_ready,
    .o_b, .o_b_valid, .i_b_ready,
    .i_ar, .i_ar_valid, .o_ar_ready,
    .o_r, .o_r_valid, .i_r_ready,
    .o_law(law), .o_law_valid(law_valid), .i_law_ready(law_ready),
    .o_lw(lw), .o_lw_valid(lw_valid), .i_lw_ready(lw_ready),
    .i_lb(lb), .i_lb_valid(lb_valid), .o_lb_ready(lb_ready),
    .o_lar(lar), .o_lar_valid(lar_valid), .i_lar_ready(lar_ready),
    .i_lr(lr), .i_lr_valid(lr_valid), .o_lr_ready(lr_ready)
  );

  // Lane j holds every word whose index is j modulo NUM_S
  for (genvar j = 0; j < NUM_S; j++) begin : g_lane
    axi_word_mem i_axi_word_mem (
      .clk, .i_rst,
      .i_aw(law[j]), .i_aw_valid(law_valid[j]), .o_aw_ready(law_ready[j]),
      .i_w(lw[j]), .i_w_valid(lw_valid[j]), .o_w_ready(lw_ready[j]),
      .o_b(lb[j]), .o_b_valid(lb_valid[j]), .i_b_ready(lb_ready[j]),
      .i_ar(lar[j]), .i_ar_valid(lar_valid[j]), .o_ar_ready(lar_ready[j]),
      .o_r(lr[j]), .o_r_valid(lr_valid[j]), .i_r_ready(lr_ready[j])
    );
  end

endmodule

`default_nettype wire

// File: tb_stripe_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module tb_stripe_checker (
  input  logic                   clk,
  input  logic                   i_rst,
  input  axi_types_pkg::axi_aw_t i_aw,
  input  logic                   i_aw_valid,
  input  logic                   i_aw_ready,
  input  axi_types_pkg::axi_w_t  i_w,
  input  logic                   i_w_valid,
  input  logic                   i_w_ready,
  input  axi_types_pkg::axi_b_t  i_b,
  input  logic                   i_b_valid,
  input  logic                   i_b_ready,
  input  axi_types_pkg::axi_ar_t i_ar,
  input  logic                   i_ar_valid,
  input  logic                   i_ar_ready,
  input  axi_types_pkg::axi_r_t  i_r,
  input  logic                   i_r_valid,
  input  logic                   i_r_ready,
  output int                     o_errors,
  output int                     o_checks
);
  import axi_types_pkg::*;
  import stripe_pkg::*;

  // Word indices at or above this are out of range
  localparam int MEM_WORDS = `STRIPE_NUM_S * `STRIPE_LANE_WORDS;
  localparam int STRB_W = `STRIPE_DATA_W / 8;

  logic [`STRIPE_DATA_W-1:0] model [MEM_WORDS];
  int                        errors = 0;
  int                        checks = 0;
  int                        low_cycles = 0;
  logic                      rst_seen = 1'b0;
  logic                      wr_open = 1'b0;
  int                        wr_word;
  int                        wr_beats;
  int                        wr_seen;
  logic                      wr_err;
  logic [`STRIPE_ID_W-1:0]   wr_id;
  logic                      rd_open = 1'b0;
  int                        rd_word;
  int                        rd_beats;
  int                        rd_seen;
  logic [`STRIPE_ID_W-1:0]   rd_id;

  assign o_errors = errors;
  assign o_checks = checks;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  always @(posedge clk) begin
    int                        word;
    logic [`STRIPE_DATA_W-1:0] exp_data;
    logic [1:0]                exp_resp;
    if (i_rst) begin
      // Registers are only known after the first reset edge
      if (rst_seen) begin
        check_value("o_b_valid in reset", 32'(i_b_valid), 32'd0);
        check_value("o_r_valid in reset", 32'(i_r_valid), 32'd0);
      end
      rst_seen = 1'b1;
      low_cycles = 0;
    end else begin
      if (low_cycles == 0) begin
        check_value("o_b_valid after reset", 32'(i_b_valid), 32'd0);
        check_value("o_r_valid after reset", 32'(i_r_valid), 32'd0);
      end else if (low_cycles == 1) begin
        check_value("o_aw_ready after reset", 32'(i_aw_ready), 32'd1);
        check_value("o_ar_ready after reset", 32'(i_ar_ready), 32'd1);
      end
      if (low_cycles < 2) begin
        low_cycles++;
      end

      if (i_aw_valid && i_aw_ready) begin
        if (wr_open) begin
          report_error("write address accepted while a write burst was still open");
        end
        wr_open = 1'b1;
        wr_word = int'(i_aw.addr >> BYTE_BITS);
        wr_beats = int'(i_aw.len) + 1;
        wr_seen = 0;
        wr_err = 1'b0;
        wr_id = i_aw.id;
      end

      if (i_w_valid && i_w_ready) begin
        word = wr_word + wr_seen;
        if (!wr_open || wr_seen >= wr_beats) begin
          report_error("write data beat accepted outside any write burst");
        end else if (word < MEM_WORDS) begin
          for (int k = 0; k < STRB_W; k++) begin
            if (i_w.strb[k]) begin
              model[word][8*k +: 8] = i_w.data[8*k +: 8];
            end
          end
        end else begin
          wr_err = 1'b1;
        end
        wr_seen++;
      end

      if (i_b_valid && i_b_ready) begin
        if (!wr_open) begin
          report_error("write response arrived with no write burst outstanding");
        end else begin
          check_value("write beats before B", wr_seen, wr_beats);
          check_value("B id", 32'(i_b.id), 32'(wr_id));
          check_value("B resp", 32'(i_b.resp),
                      wr_err ? 32'(RESP_SLVERR) : 32'(RESP_OKAY));
          wr_open = 1'b0;
        end
      end

      if (i_ar_valid && i_ar_ready) begin
        if (rd_open) begin
          report_error("read address accepted while a read burst was still open");
        end
        rd_open = 1'b1;
        rd_word = int'(i_ar.addr >> BYTE_BITS);
        rd_beats = int'(i_ar.len) + 1;
        rd_seen = 0;
        rd_id = i_ar.id;
      end

      if (i_r_valid && i_r_ready) begin
        if (!rd_open) begin
          report_error("read data beat arrived with no read burst outstanding");
        end else begin
          word = rd_word + rd_seen;
          if (word < MEM_WORDS) begin
            exp_data = model[word];
            exp_resp = RESP_OKAY;
          end else begin
            exp_data = '0;
            exp_resp = RESP_SLVERR;
          end
          check_value($sformatf("R data of word %0d", word), 32'(i_r.data), 32'(exp_data));
          check_value($sformatf("R resp of word %0d", word), 32'(i_r.resp), 32'(exp_resp));
          check_value($sformatf("R last of word %0d", word), 32'(i_r.last),
                      32'(rd_seen == rd_beats - 1));
          check_value("R id", 32'(i_r.id), 32'(rd_id));
          rd_seen++;
          if (rd_seen == rd_beats) begin
            rd_open = 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_stripe.sv
`timescale 1ns/1ps
`default_nettype none

`include "stripe_macros.svh"

module tb_stripe;
  import axi_types_pkg::*;
  import stripe_pkg::*;

  localparam int NUM_S = `STRIPE_NUM_S;
  localparam int MAX_BEATS = 16;
  localparam int STRB_W = `STRIPE_DATA_W / 8;
  localparam int MEM_WORDS = NUM_S * `STRIPE_LANE_WORDS;
  localparam int RAND_BURSTS = 40;
  // Eight cycles per beat, margin covers the fill and the directed bursts
  localparam int TIMEOUT_CYCLES = RAND_BURSTS * MAX_BEATS * 8 + 4000;

  logic    clk;
  logic    rst;
  axi_aw_t aw;
  logic    aw_valid;
  logic    aw_ready;
  axi_w_t  w;
  logic    w_valid;
  logic    w_ready;
  axi_b_t  b;
  logic    b_valid;
  logic    b_ready;
  axi_ar_t ar;
  logic    ar_valid;
  logic    ar_ready;
  axi_r_t  r;
  logic    r_valid;
  logic    r_ready;

  int seed = 4288;
  int cycles;
  int errors;
  int checks;
  int tests_run = 0;
  int tests_failed = 0;
  int errors_before = 0;
  // Chance in percent that a ready is low in a cycle
  int bp_pct = 0;
  logic [`STRIPE_DATA_W-1:0] wdata [$];
  logic [STRB_W-1:0]         wstrb [$];

  stripe_mem_top i_stripe_mem_top (
    .clk(clk), .i_rst(rst),
    .i_aw(aw), .i_aw_valid(aw_valid), .o_aw_ready(aw_ready),
    .i_w(w), .i_w_valid(w_valid), .o_w_ready(w_ready),
    .o_b(b), .o_b_valid(b_valid), .i_b_ready(b_ready),
    .i_ar(ar), .i_ar_valid(ar_valid), .o_ar_ready(ar_ready),
    .o_r(r), .o_r_valid(r_valid), .i_r_ready(r_ready)
  );

  tb_stripe_checker i_tb_stripe_checker (
    .clk(clk), .i_rst(rst),
    .i_aw(aw), .i_aw_valid(aw_valid), .i_aw_ready(aw_ready),
    .i_w(w), .i_w_valid(w_valid), .i_w_ready(w_ready),
    .i_b(b), .i_b_valid(b_valid), .i_b_ready(b_ready),
    .i_ar(ar), .i_ar_valid(ar_valid), .i_ar_ready(ar_ready),
    .i_r(r), .i_r_valid(r_valid), .i_r_ready(r_ready),
    .o_errors(errors), .o_checks(checks)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits();
    rand_bits = $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] bits;
    bits = rand_bits();
    return int'(bits[15:0]) % n;
  endfunction

  task automatic make_data(input int beats, input logic partial);
    logic [31:0] bits;
    wdata.delete();
    wstrb.delete();
    for (int k = 0; k < beats; k++) begin
      bits = rand_bits();
      wdata.push_back(bits[`STRIPE_DATA_W-1:0]);
      bits = rand_bits();
      wstrb.push_back(partial ? bits[STRB_W-1:0] : {STRB_W{1'b1}});
    end
  endtask

  // Called just after a rising edge, returns just after the B transfer
  task automatic write_burst(input int word, input int beats);
    logic hs;
    aw <= '{id: `STRIPE_ID_W'(rand_below(16)), addr: `STRIPE_ADDR_W'(word << BYTE_BITS),
           len: 8'(beats - 1), size: 3'(BYTE_BITS), burst: 2'b01};
    aw_valid <= 1'b1;
    do @(posedge clk); while (!aw_ready);
    aw_valid <= 1'b0;
    for (int k = 0; k < beats; k++) begin
      w <= '{data: wdata[k], strb: wstrb[k], last: k == beats - 1};
      w_valid <= 1'b1;
      do @(posedge clk); while (!w_ready);
    end
    w_valid <= 1'b0;
    do begin
      @(posedge clk);
      hs = b_valid && b_ready;
      b_ready <= rand_below(100) >= bp_pct;
    end while (!hs);
  endtask

  task automatic read_burst(input int word, input int beats);
    int got;
    ar <= '{id: `STRIPE_ID_W'(rand_below(16)), addr: `STRIPE_ADDR_W'(word << BYTE_BITS),
           len: 8'(beats - 1), size: 3'(BYTE_BITS), burst: 2'b01};
    ar_valid <= 1'b1;
    do @(posedge clk); while (!ar_ready);
    ar_valid <= 1'b0;
    got = 0;
    while (got < beats) begin
      @(posedge clk);
      if (r_valid && r_ready) begin
        got++;
      end
      r_ready <= rand_below(100) >= bp_pct;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    repeat (2) @(posedge clk);
    errs = errors - errors_before;
    errors_before = errors;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %s, %0d errors", tests_run, name, errs == 0 ? "ok" : "failed", errs);
  endtask

  initial begin
    int word;
    int beats;
    rst <= 1'b1;
    aw <= '0;
    aw_valid <= 1'b0;
    w <= '0;
    w_valid <= 1'b0;
    b_ready <= 1'b0;
    ar <= '0;
    ar_valid <= 1'b0;
    r_ready <= 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    do @(posedge clk); while (!(aw_ready && ar_ready));
    end_test("reset");

    // Fill every in-range word so later reads have known data
    for (word = 0; word < MEM_WORDS; word += MAX_BEATS) begin
      make_data(MAX_BEATS, 1'b0);
      write_burst(word, MAX_BEATS);
    end
    for (word = 0; word < MEM_WORDS; word += MAX_BEATS) begin
      read_burst(word, MAX_BEATS);
    end
    end_test("write then read back");

    for (int n = 0; n < 4; n++) begin
      word = rand_below(MEM_WORDS - 8) & ~(NUM_S - 1);
      make_data(8, 1'b1);
      write_burst(word, 8);
      read_burst(word, 8);
    end
    end_test("partial strobes");

    bp_pct = 50;
    for (int n = 0; n < 6; n++) begin
      word = rand_below(MEM_WORDS - MAX_BEATS) & ~(NUM_S - 1);
      make_data(MAX_BEATS, 1'b1);
      write_burst(word, MAX_BEATS);
      read_burst(word, MAX_BEATS);
    end
    end_test("ready back-pressure");

    // Straddles the end of the memory, then lies wholly beyond it
    bp_pct = 30;
    make_data(8, 1'b0);
    write_burst(MEM_WORDS - 4, 8);
    read_burst(MEM_WORDS - 4, 8);
    make_data(8, 1'b0);
    write_burst(MEM_WORDS + 16, 8);
    read_burst(MEM_WORDS + 16, 8);
    read_burst(MEM_WORDS - 8, 8);
    end_test("out of range");

    for (int n = 0; n < RAND_BURSTS; n++) begin
      word = rand_below(MEM_WORDS + 8) & ~(NUM_S - 1);
      beats = NUM_S * (1 + rand_below(MAX_BEATS / NUM_S));
      if (rand_below(2) == 0) begin
        make_data(beats, rand_below(2) == 0);
        write_burst(word, beats);
      end else begin
        read_burst(word, beats);
      end
    end
    end_test("random bursts");

    $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
stripe_pkg.sv
axi_types_pkg.sv
stripe_wr.sv
stripe_rd.sv
axi_stripe.sv
axi_word_mem.sv
stripe_mem_top.sv
tb_stripe_checker.sv
tb_stripe.sv

// File: run_sim.sh
#!/bin/sh
# Build the striped memory testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --top-module tb_stripe -f vlog.f --Mdir "$OBJ" -o tb_stripe
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_stripe" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
